/* Bender.yml */
package:
  name: tiny_soc

sources:
  - common/tiny_core_pkg.sv
  - common/obi_if.sv
  - common/instr_stream_if.sv
  - design/core/fetch_unit.sv
  - design/core/exec_unit.sv
  - design/obi_ram.sv
  - design/data_bus_split.sv
  - design/soc_dut_wrap.sv
  - target: test
    files:
      - test/soc_checker.sv
      - test/tb_soc.sv

/* build.f */
common/tiny_core_pkg.sv
common/obi_if.sv
common/instr_stream_if.sv
design/core/fetch_unit.sv
design/core/exec_unit.sv
design/obi_ram.sv
design/data_bus_split.sv
design/soc_dut_wrap.sv
test/soc_checker.sv
test/tb_soc.sv

/* common/instr_stream_if.sv */
// Fetch-to-execute stream; redirect is a single-cycle pulse that overrides any buffered instruction
`timescale 1ns/1ps

interface instr_stream_if;
    // Forward path, transfer when valid and ready are both high
    logic                             valid;
    logic                             ready;
    logic [tiny_core_pkg::XLEN-1:0]   instr;
    logic [tiny_core_pkg::ADDR_W-1:0] pc;

    // Backward path, taken branch target
    logic                             redir_valid;
    logic [tiny_core_pkg::ADDR_W-1:0] redir_pc;

    // Fetch side
    modport producer (
        output valid, instr, pc,
        input  ready, redir_valid, redir_pc
    );

    // Execute side
    modport consumer (
        input  valid, instr, pc,
        output ready, redir_valid, redir_pc
    );
endinterface

/* common/obi_if.sv */
// Plain OBI-style bundles without byte enables, errors or user fields; grant may be combinational
`timescale 1ns/1ps

// ------------------------------
// Read/write data bus
// ------------------------------
interface obi_if;
    logic                             req;
    logic                             gnt;
    logic [tiny_core_pkg::ADDR_W-1:0] addr;
    logic                             we;
    logic [tiny_core_pkg::XLEN-1:0]   wdata;
    logic                             rvalid;
    logic [tiny_core_pkg::XLEN-1:0]   rdata;

    // Bus initiator, holds req/addr/wdata until gnt
    modport manager (
        output req, addr, we, wdata,
        input  gnt, rvalid, rdata
    );

    // Bus target, one rvalid per granted request
    modport subordinate (
        input  req, addr, we, wdata,
        output gnt, rvalid, rdata
    );
endinterface

// ------------------------------
// Read-only instruction bus
// ------------------------------
interface obi_rd_if;
    logic                             req;
    logic                             gnt;
    logic [tiny_core_pkg::ADDR_W-1:0] addr;
    logic                             rvalid;
    logic [tiny_core_pkg::XLEN-1:0]   rdata;

    modport manager (output req, addr, input gnt, rvalid, rdata);
    modport subordinate (input req, addr, output gnt, rvalid, rdata);
endinterface

/* common/tiny_core_pkg.sv */
// Shared sizes and encodings; all bus accesses are full 32-bit words, data space is 16-bit bytes
package tiny_core_pkg;

    // ------------------------------
    // Datapath and address widths
    // ------------------------------

    // Accumulator, instruction and bus data width
    localparam int XLEN = 32;

    // Width of the immediate/address field of an instruction
    localparam int IMM_W = 16;

    // Byte address width on both buses, same as the immediate field
    localparam int ADDR_W = IMM_W;

    // ------------------------------
    // Instruction fields
    // ------------------------------

    // Opcode sits in the top nibble
    localparam int OP_MSB = 31;
    localparam int OP_LSB = 28;

    // Opcodes; codes 8 to 15 run as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_LD   = 4'h2,
        OP_ST   = 4'h3,
        OP_ADD  = 4'h4,
        OP_SUB  = 4'h5,
        OP_BNZ  = 4'h6,
        OP_HALT = 4'h7
    } op_e;

    // ------------------------------
    // Memory
    // ------------------------------

    // Word RAM, instructions and data share it
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;

    // Lowest byte address bit that selects a word
    // Word index is addr[RAM_AW+WORD_LSB-1:WORD_LSB], i.e. bits 11:2
    localparam int WORD_LSB = 2;

    // Byte step between instructions
    localparam logic [ADDR_W-1:0] INSTR_STEP = 16'd4;

    // First fetch address after reset
    localparam logic [ADDR_W-1:0] RESET_PC = 16'h0000;

    // ------------------------------
    // Peripheral address map
    // ------------------------------

    // Everything at or above this is peripheral space, reads give zero
    localparam logic [ADDR_W-1:0] PERIPH_BASE = 16'hF000;

    // Writes emit the low byte as a character
    localparam logic [ADDR_W-1:0] STDOUT_ADDR = 16'hF000;

    // Writes end the program with a 32-bit code
    localparam logic [ADDR_W-1:0] EXIT_ADDR = 16'hF004;

endpackage

/* design/core/exec_unit.sv */
// Accumulator execute stage; one data access at a time, HALT sleeps until reset
`timescale 1ns/1ps

module exec_unit (
    input  logic             clk_i,
    input  logic             rst_i,
    instr_stream_if.consumer istream,
    obi_if.manager           dbus,
    output logic             core_sleep_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA_REQ,
        ST_DATA_WAIT,
        ST_HALTED
    } state_e;

    state_e state_q;

    logic [tiny_core_pkg::XLEN-1:0] acc_q;

    // Memory operation in progress
    tiny_core_pkg::op_e               mem_op_q;
    logic [tiny_core_pkg::ADDR_W-1:0] mem_addr_q;

    // ------------------------------
    // Decode
    // ------------------------------
    tiny_core_pkg::op_e              op;
    logic [tiny_core_pkg::IMM_W-1:0] imm;
    logic                            take;
    logic                            is_mem_op;
    logic                            fall_through;

    assign op  = tiny_core_pkg::op_e'(istream.instr[tiny_core_pkg::OP_MSB:tiny_core_pkg::OP_LSB]);
    assign imm = istream.instr[tiny_core_pkg::IMM_W-1:0];

    // New instructions only in IDLE
    assign istream.ready = (state_q == ST_IDLE);
    assign take          = istream.valid & istream.ready;

    assign is_mem_op = (op == tiny_core_pkg::OP_LD)  | (op == tiny_core_pkg::OP_ST) |
                       (op == tiny_core_pkg::OP_ADD) | (op == tiny_core_pkg::OP_SUB);

    // A branch to the next word needs no flush
    assign fall_through = (imm == istream.pc + tiny_core_pkg::INSTR_STEP);

    // Taken BNZ, single pulse since the instruction leaves the buffer
    assign istream.redir_valid = take & (op == tiny_core_pkg::OP_BNZ) &
                                 (acc_q != '0) & ~fall_through;
    assign istream.redir_pc    = imm;

    // ------------------------------
    // Data bus
    // ------------------------------
    assign dbus.req   = (state_q == ST_DATA_REQ);
    assign dbus.addr  = mem_addr_q;
    assign dbus.we    = (mem_op_q == tiny_core_pkg::OP_ST);
    // Accumulator is frozen until the access ends
    assign dbus.wdata = acc_q;

    assign core_sleep_o = (state_q == ST_HALTED);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            acc_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (take) begin
                        if (op == tiny_core_pkg::OP_LDI) begin
                            // Zero-extended immediate
                            acc_q <= {{(tiny_core_pkg::XLEN - tiny_core_pkg::IMM_W){1'b0}}, imm};
                        end else if (op == tiny_core_pkg::OP_HALT) begin
                            state_q <= ST_HALTED;
                        end else if (is_mem_op) begin
                            state_q <= ST_DATA_REQ;
                        end
                        // NOP, BNZ and unused codes leave the state alone
                    end
                end
                ST_DATA_REQ: begin
                    if (dbus.gnt) begin
                        state_q <= ST_DATA_WAIT;
                    end
                end
                ST_DATA_WAIT: begin
                    if (dbus.rvalid) begin
                        state_q <= ST_IDLE;
                        case (mem_op_q)
                            tiny_core_pkg::OP_LD:  acc_q <= dbus.rdata;
                            tiny_core_pkg::OP_ADD: acc_q <= acc_q + dbus.rdata;
                            tiny_core_pkg::OP_SUB: acc_q <= acc_q - dbus.rdata;
                            // ST completes with no change
                            default: acc_q <= acc_q;
                        endcase
                    end
                end
                default: begin
                    // Halted, only reset leaves
                    state_q <= ST_HALTED;
                end
            endcase
        end
    end

    // Operation and address latched at acceptance
    always_ff @(posedge clk_i) begin
        if (take && is_mem_op) begin
            mem_op_q   <= op;
            mem_addr_q <= imm;
        end
    end

endmodule

/* design/core/fetch_unit.sv */
// Sequential fetcher with one outstanding read; relies on a RAM that answers one cycle after gnt
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             fetch_en_i,
    obi_rd_if.manager        ibus,
    instr_stream_if.producer istream
);

    // Next fetch address and address of the fetch in flight
    logic [tiny_core_pkg::ADDR_W-1:0] pc_q;
    logic [tiny_core_pkg::ADDR_W-1:0] req_pc_q;

    // Outstanding read, and whether its data is to be thrown away
    logic inflight_q;
    logic stale_q;

    // One-entry instruction buffer
    logic                             buf_valid_q;
    logic [tiny_core_pkg::XLEN-1:0]   buf_instr_q;
    logic [tiny_core_pkg::ADDR_W-1:0] buf_pc_q;

    logic take;
    logic issue;
    logic resp_keep;

    // Execute accepts the buffered word this cycle
    assign take = buf_valid_q & istream.ready;

    // ------------------------------
    // Request side
    // ------------------------------
    // Only issue if the buffer will be free when the data returns
    assign ibus.req  = fetch_en_i & ~inflight_q & (~buf_valid_q | take);
    assign ibus.addr = pc_q;
    assign issue     = ibus.req & ibus.gnt;

    // Response is kept unless it belongs to the old path
    assign resp_keep = ibus.rvalid & ~stale_q & ~istream.redir_valid;

    assign istream.valid = buf_valid_q;
    assign istream.instr = buf_instr_q;
    assign istream.pc    = buf_pc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q        <= tiny_core_pkg::RESET_PC;
            inflight_q  <= 1'b0;
            stale_q     <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            // Redirect wins over the sequential step
            if (istream.redir_valid) begin
                pc_q <= istream.redir_pc;
            end else if (issue) begin
                pc_q <= pc_q + tiny_core_pkg::INSTR_STEP;
            end

            if (issue) begin
                inflight_q <= 1'b1;
            end else if (ibus.rvalid) begin
                inflight_q <= 1'b0;
            end

            // Any read still due after a redirect is from the old path
            if (istream.redir_valid) begin
                stale_q <= issue | (inflight_q & ~ibus.rvalid);
            end else if (ibus.rvalid) begin
                stale_q <= 1'b0;
            end

            if (istream.redir_valid) begin
                buf_valid_q <= 1'b0;
            end else if (resp_keep) begin
                buf_valid_q <= 1'b1;
            end else if (take) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    // Payload, follows the control above
    always_ff @(posedge clk_i) begin
        if (issue) begin
            req_pc_q <= pc_q;
        end
        if (resp_keep) begin
            buf_instr_q <= ibus.rdata;
            buf_pc_q    <= req_pc_q;
        end
    end

endmodule

/* design/data_bus_split.sv */
// Data-side address decoder; peripheral writes outside stdout/exit are ignored, reads there give zero
`timescale 1ns/1ps

module data_bus_split (
    input  logic        clk_i,
    input  logic        rst_i,
    obi_if.subordinate  core_bus,
    obi_if.manager      ram_bus,
    output logic        stdout_valid_o,
    output logic [7:0]  stdout_char_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_code_o
);

    logic is_periph;
    logic periph_acc;

    // Source of the outstanding response, set at grant
    logic resp_periph_q;
    logic periph_rvalid_q;

    // Peripheral write pulses and their payload
    logic        stdout_q;
    logic        exit_q;
    logic [7:0]  char_q;
    logic [31:0] code_q;

    assign is_periph  = (core_bus.addr >= tiny_core_pkg::PERIPH_BASE);
    assign periph_acc = core_bus.req & is_periph;

    // ------------------------------
    // RAM path, passes straight through
    // ------------------------------
    assign ram_bus.req   = core_bus.req & ~is_periph;
    assign ram_bus.addr  = core_bus.addr;
    assign ram_bus.we    = core_bus.we;
    assign ram_bus.wdata = core_bus.wdata;

    // Peripherals grant at once
    assign core_bus.gnt    = is_periph ? core_bus.req : ram_bus.gnt;
    assign core_bus.rvalid = periph_rvalid_q | ram_bus.rvalid;
    assign core_bus.rdata  = resp_periph_q ? '0 : ram_bus.rdata;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_periph_q   <= 1'b0;
            periph_rvalid_q <= 1'b0;
            stdout_q        <= 1'b0;
            exit_q          <= 1'b0;
        end else begin
            if (core_bus.req && core_bus.gnt) begin
                resp_periph_q <= is_periph;
            end
            periph_rvalid_q <= periph_acc;
            // Pulses line up with the peripheral rvalid
            stdout_q <= periph_acc & core_bus.we & (core_bus.addr == tiny_core_pkg::STDOUT_ADDR);
            exit_q   <= periph_acc & core_bus.we & (core_bus.addr == tiny_core_pkg::EXIT_ADDR);
        end
    end

    // Write data captured with the access
    always_ff @(posedge clk_i) begin
        if (periph_acc && core_bus.we) begin
            char_q <= core_bus.wdata[7:0];
            code_q <= core_bus.wdata;
        end
    end

    assign stdout_valid_o = stdout_q;
    assign stdout_char_o  = char_q;
    assign exit_valid_o   = exit_q;
    assign exit_code_o    = code_q;

endmodule

/* design/obi_ram.sv */
// Single-cycle word RAM; grants at once, no reset on contents, load port must not race data writes
`timescale 1ns/1ps

module obi_ram (
    input  logic                             clk_i,
    obi_rd_if.subordinate                    ibus,
    obi_if.subordinate                       dbus,
    input  logic                             load_en_i,
    input  logic [tiny_core_pkg::RAM_AW-1:0] load_addr_i,
    input  logic [tiny_core_pkg::XLEN-1:0]   load_data_i
);

    localparam int WL = tiny_core_pkg::WORD_LSB;
    localparam int AW = tiny_core_pkg::RAM_AW;

    logic [tiny_core_pkg::XLEN-1:0] mem [tiny_core_pkg::RAM_WORDS];

    // Word indices from byte addresses
    logic [AW-1:0] i_idx;
    logic [AW-1:0] d_idx;

    // Registered responses
    logic                           i_rvalid_q;
    logic [tiny_core_pkg::XLEN-1:0] i_rdata_q;
    logic                           d_rvalid_q;
    logic [tiny_core_pkg::XLEN-1:0] d_rdata_q;

    assign i_idx = ibus.addr[WL +: AW];
    assign d_idx = dbus.addr[WL +: AW];

    // Always ready, grant follows request
    assign ibus.gnt = ibus.req;
    assign dbus.gnt = dbus.req;

    assign ibus.rvalid = i_rvalid_q;
    assign ibus.rdata  = i_rdata_q;
    assign dbus.rvalid = d_rvalid_q;
    assign dbus.rdata  = d_rdata_q;

    // ------------------------------
    // Write port
    // ------------------------------
    // Load port first, data writes otherwise
    always_ff @(posedge clk_i) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end else if (dbus.req && dbus.we) begin
            mem[d_idx] <= dbus.wdata;
        end
    end

    // ------------------------------
    // Read ports
    // ------------------------------
    // rvalid one cycle after each grant
    always_ff @(posedge clk_i) begin
        i_rvalid_q <= ibus.req;
        d_rvalid_q <= dbus.req;
    end

    always_ff @(posedge clk_i) begin
        if (ibus.req) begin
            i_rdata_q <= mem[i_idx];
        end
        // A write returns the old word, the core ignores it
        if (dbus.req) begin
            d_rdata_q <= mem[d_idx];
        end
    end

endmodule

/* design/soc_dut_wrap.sv */
// Harness top level; program load is only legal while fetch_en_i is low
`timescale 1ns/1ps

module soc_dut_wrap (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             fetch_en_i,

    // Program loader
    input  logic                             load_en_i,
    input  logic [tiny_core_pkg::RAM_AW-1:0] load_addr_i,
    input  logic [31:0]                      load_data_i,

    // Virtual peripherals
    output logic                             stdout_valid_o,
    output logic [7:0]                       stdout_char_o,
    output logic                             exit_valid_o,
    output logic [31:0]                      exit_code_o,

    output logic                             core_sleep_o
);

    // ------------------------------
    // Internal buses
    // ------------------------------
    obi_rd_if       instr_bus ();
    obi_if          core_dbus ();
    obi_if          ram_dbus ();
    instr_stream_if istream ();

    // Core, split into fetch and execute
    fetch_unit i_fetch (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fetch_en_i (fetch_en_i),
        .ibus       (instr_bus),
        .istream    (istream)
    );

    exec_unit i_exec (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .istream      (istream),
        .dbus         (core_dbus),
        .core_sleep_o (core_sleep_o)
    );

    // Data side decode to RAM or peripherals
    data_bus_split i_split (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .core_bus       (core_dbus),
        .ram_bus        (ram_dbus),
        .stdout_valid_o (stdout_valid_o),
        .stdout_char_o  (stdout_char_o),
        .exit_valid_o   (exit_valid_o),
        .exit_code_o    (exit_code_o)
    );

    // Shared instruction and data memory
    obi_ram i_ram (
        .clk_i       (clk_i),
        .ibus        (instr_bus),
        .dbus        (ram_dbus),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

endmodule

/* test/soc_checker.sv */
// Bus and reset assertions; assumes grant in the request cycle and one-cycle read latency
`timescale 1ns/1ps

module soc_checker (
    input logic        clk_i,
    input logic        rst_i,
    input logic        req_i,
    input logic        gnt_i,
    input logic [15:0] addr_i,
    input logic        rvalid_i,
    input logic        stdout_i,
    input logic        exit_i
);

    // ------------------------------
    // Handshake rules
    // ------------------------------

    // Pending request keeps its address
    req_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
        req_i && !gnt_i |=> req_i && $stable(addr_i))
        else $error("request dropped or address changed before grant");

    // Every grant is answered in the next cycle
    gnt_to_rvalid_a : assert property (@(posedge clk_i) disable iff (rst_i)
        req_i && gnt_i |=> rvalid_i)
        else $error("no rvalid one cycle after grant");

    // No response without a grant one cycle earlier
    rvalid_from_gnt_a : assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_i |-> $past(req_i && gnt_i))
        else $error("rvalid without a grant in the previous cycle");

    // Peripherals stay quiet once reset has been seen
    quiet_in_reset_a : assert property (@(posedge clk_i)
        rst_i |=> !stdout_i && !exit_i)
        else $error("peripheral pulse while reset is active");

endmodule

// RAM has no reset input, its ports run from the first edge
bind obi_ram soc_checker i_ibus_chk (
    .clk_i    (clk_i),
    .rst_i    (1'b0),
    .req_i    (ibus.req),
    .gnt_i    (ibus.gnt),
    .addr_i   (ibus.addr),
    .rvalid_i (ibus.rvalid),
    .stdout_i (1'b0),
    .exit_i   (1'b0)
);

bind obi_ram soc_checker i_dbus_chk (
    .clk_i    (clk_i),
    .rst_i    (1'b0),
    .req_i    (dbus.req),
    .gnt_i    (dbus.gnt),
    .addr_i   (dbus.addr),
    .rvalid_i (dbus.rvalid),
    .stdout_i (1'b0),
    .exit_i   (1'b0)
);

// Core side of the splitter, covers both RAM and peripheral responses
bind data_bus_split soc_checker i_split_chk (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (core_bus.req),
    .gnt_i    (core_bus.gnt),
    .addr_i   (core_bus.addr),
    .rvalid_i (core_bus.rvalid),
    .stdout_i (stdout_valid_o),
    .exit_i   (exit_valid_o)
);

/* test/tb_soc.sv */
// Directed tests with a small ISA model; every program ends in HALT so stale RAM never executes
`timescale 1ns/1ps

module tb_soc;

    // 5 tests x 200 instructions x 4 cycles, with a margin of 5
    localparam int MAX_CYCLES = 20000;

    logic        clk_i;
    logic        rst_i;
    logic        fetch_en_i;
    logic        load_en_i;
    logic [9:0]  load_addr_i;
    logic [31:0] load_data_i;
    logic        stdout_valid_o;
    logic [7:0]  stdout_char_o;
    logic        exit_valid_o;
    logic [31:0] exit_code_o;
    logic        core_sleep_o;

    // Model memory mirrors every loaded word
    logic [31:0] model_mem [1024];
    logic [7:0]  model_out [$];
    logic [31:0] model_code;
    logic        model_exit;

    // Observed DUT results
    logic [7:0]  dut_out [$];
    logic [31:0] dut_code;

    logic [9:0]  prog_pc;
    integer      seed;
    int          cycles;
    int          errors;

    soc_dut_wrap i_dut (.*);

    always #50 clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error at %0t: %s, expected %h, got %h", $time, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Failure at %0t: %s", $time, why);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        rst_i      = 1'b1;
        fetch_en_i = 1'b0;
        load_en_i  = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i   = 1'b0;
        prog_pc = '0;
    endtask

    // One word per cycle through the load port, load_en_i drops in run_program
    task automatic put_word(input logic [9:0] idx, input logic [31:0] data);
        @(posedge clk_i);
        #1;
        load_en_i      = 1'b1;
        load_addr_i    = idx;
        load_data_i    = data;
        model_mem[idx] = data;
    endtask

    // Append an instruction at the next program word
    task automatic emit(input tiny_core_pkg::op_e op, input logic [15:0] imm);
        put_word(prog_pc, {op, 12'h000, imm});
        prog_pc++;
    endtask

    // ------------------------------
    // Instruction set model
    // ------------------------------
    task automatic run_model();
        logic [15:0] pc;
        logic [31:0] acc;
        logic [31:0] ins;
        logic [31:0] opnd;
        logic [15:0] imm;
        logic        halted;
        int          steps;
        pc         = tiny_core_pkg::RESET_PC;
        acc        = '0;
        halted     = 1'b0;
        steps      = 0;
        model_exit = 1'b0;
        model_code = '0;
        model_out.delete();
        while (!model_exit && !halted && steps < 1000) begin
            ins  = model_mem[pc[11:2]];
            imm  = ins[15:0];
            // Peripheral space reads as zero
            opnd = (imm >= tiny_core_pkg::PERIPH_BASE) ? 32'h0 : model_mem[imm[11:2]];
            pc   = pc + 16'd4;
            case (ins[31:28])
                tiny_core_pkg::OP_LDI:  acc = {16'h0000, imm};
                tiny_core_pkg::OP_LD:   acc = opnd;
                tiny_core_pkg::OP_ADD:  acc = acc + opnd;
                tiny_core_pkg::OP_SUB:  acc = acc - opnd;
                tiny_core_pkg::OP_BNZ:  if (acc != 0) pc = imm;
                tiny_core_pkg::OP_HALT: halted = 1'b1;
                tiny_core_pkg::OP_ST: begin
                    if (imm == tiny_core_pkg::STDOUT_ADDR) begin
                        model_out.push_back(acc[7:0]);
                    end else if (imm == tiny_core_pkg::EXIT_ADDR) begin
                        model_exit = 1'b1;
                        model_code = acc;
                    end else if (imm < tiny_core_pkg::PERIPH_BASE) begin
                        model_mem[imm[11:2]] = acc;
                    end
                end
                default: ;
            endcase
            steps++;
        end
    endtask

    // Enable fetch and collect output up to the exit pulse
    task automatic run_program();
        logic done;
        done = 1'b0;
        dut_out.delete();
        @(posedge clk_i);
        #1;
        load_en_i  = 1'b0;
        fetch_en_i = 1'b1;
        while (!done) begin
            @(negedge clk_i);
            if (core_sleep_o && !exit_valid_o) begin
                abort_run("core went to sleep before writing the exit register");
            end
            if (stdout_valid_o) begin
                dut_out.push_back(stdout_char_o);
            end
            if (exit_valid_o) begin
                dut_code = exit_code_o;
                done     = 1'b1;
            end
        end
    endtask

    task automatic compare_run(input string name);
        int k;
        check_eq({name, ": model reached exit"}, 32'd1, {31'd0, model_exit});
        check_eq({name, ": stdout length"}, model_out.size(), dut_out.size());
        for (k = 0; k < model_out.size(); k++) begin
            check_eq({name, ": stdout character"}, model_out[k], dut_out[k]);
        end
        check_eq({name, ": exit code"}, model_code, dut_code);
    endtask

    // acc = a + b - c, stored at 0x40C and read back into exit
    task automatic load_arith(input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
        put_word(10'd256, a);
        put_word(10'd257, b);
        put_word(10'd258, c);
        emit(tiny_core_pkg::OP_LD, 16'h0400);
        emit(tiny_core_pkg::OP_ADD, 16'h0404);
        emit(tiny_core_pkg::OP_SUB, 16'h0408);
        emit(tiny_core_pkg::OP_ST, 16'h040C);
        emit(tiny_core_pkg::OP_LDI, 16'h0000);
        emit(tiny_core_pkg::OP_LD, 16'h040C);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::EXIT_ADDR);
        emit(tiny_core_pkg::OP_HALT, 16'h0000);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_idle_outputs();
        apply_reset();
        repeat (20) begin
            @(negedge clk_i);
            check_eq("idle: stdout_valid_o", 32'd0, {31'd0, stdout_valid_o});
            check_eq("idle: exit_valid_o", 32'd0, {31'd0, exit_valid_o});
            check_eq("idle: core_sleep_o", 32'd0, {31'd0, core_sleep_o});
        end
    endtask

    task automatic test_hello();
        apply_reset();
        emit(tiny_core_pkg::OP_LDI, 16'h004F);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::STDOUT_ADDR);
        emit(tiny_core_pkg::OP_LDI, 16'h004B);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::STDOUT_ADDR);
        emit(tiny_core_pkg::OP_LDI, 16'h0007);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::EXIT_ADDR);
        emit(tiny_core_pkg::OP_HALT, 16'h0000);
        run_model();
        run_program();
        check_eq("hello: character count", 32'd2, dut_out.size());
        check_eq("hello: first character", 32'h4F, dut_out[0]);
        check_eq("hello: second character", 32'h4B, dut_out[1]);
        check_eq("hello: exit code", 32'd7, dut_code);
        compare_run("hello");
    endtask

    task automatic test_arith();
        apply_reset();
        // Sum wraps past 2^32
        load_arith(32'hFFFF_FFF0, 32'h0000_0025, 32'h0000_1234);
        run_model();
        run_program();
        compare_run("arith");
    endtask

    task automatic test_loop();
        apply_reset();
        put_word(10'd256, 32'd5);
        put_word(10'd257, 32'd1);
        // Loop body at bytes 0 to 20, branch back to 0
        emit(tiny_core_pkg::OP_LDI, 16'h0041);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::STDOUT_ADDR);
        emit(tiny_core_pkg::OP_LD, 16'h0400);
        emit(tiny_core_pkg::OP_SUB, 16'h0404);
        emit(tiny_core_pkg::OP_ST, 16'h0400);
        emit(tiny_core_pkg::OP_BNZ, 16'h0000);
        // Wrong-path word right after the branch
        emit(tiny_core_pkg::OP_LDI, 16'h002A);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::EXIT_ADDR);
        emit(tiny_core_pkg::OP_HALT, 16'h0000);
        run_model();
        run_program();
        check_eq("loop: character count", 32'd5, dut_out.size());
        compare_run("loop");
    endtask

    task automatic test_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        repeat (3) begin
            a = $random(seed);
            b = $random(seed);
            c = $random(seed);
            apply_reset();
            load_arith(a, b, c);
            run_model();
            run_program();
            compare_run("random");
        end
    endtask

    task automatic test_halt();
        apply_reset();
        emit(tiny_core_pkg::OP_LDI, 16'h0048);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::STDOUT_ADDR);
        emit(tiny_core_pkg::OP_LDI, 16'h0003);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::EXIT_ADDR);
        emit(tiny_core_pkg::OP_HALT, 16'h0000);
        // Never reached once halted
        emit(tiny_core_pkg::OP_LDI, 16'h0058);
        emit(tiny_core_pkg::OP_ST, tiny_core_pkg::STDOUT_ADDR);
        run_model();
        run_program();
        compare_run("halt");
        repeat (50) begin
            @(negedge clk_i);
            if (stdout_valid_o) begin
                abort_run("stdout pulse after HALT");
            end
        end
        check_eq("halt: core_sleep_o", 32'd1, {31'd0, core_sleep_o});
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        fetch_en_i  = 1'b0;
        load_en_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        prog_pc     = '0;
        cycles      = 0;
        errors      = 0;
        seed        = 32'h0881a0c5;
        test_idle_outputs();
        test_hello();
        test_arith();
        test_loop();
        test_random();
        test_halt();
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
